// ==== rtl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  // ********************
  // Wishbone bus widths
  // ********************

  localparam int wb_data_width = 32;
  localparam int wb_addr_width = 32;
  localparam int wb_sel_width  = wb_data_width / 8;

  // Word address drops the byte offset within a 32-bit word
  localparam int wb_word_adr_width = wb_addr_width - 2;

  // ********************
  // Data word views
  // ********************

  // One Wishbone data word, seen either as two halfwords
  // (one per HyperBus beat, beat 0 is the low half) or as four bytes
  // (one per byte select)
  typedef union packed {
    logic [1:0][wb_data_width/2-1:0]  half;
    logic [wb_sel_width-1:0][7:0]     bytes;
  } wb_word_u;

endpackage

`default_nettype wire

// ==== rtl/hbus_pkg.sv ====
`default_nettype none

package hbus_pkg;

  // ********************
  // HyperBus port widths
  // ********************

  localparam int hbus_data_width = 16;
  localparam int hbus_addr_width = 32;

  // A high mask bit means the byte lane is not written
  localparam int hbus_mask_width = hbus_data_width / 8;

  localparam int beats_per_word = 2;
  localparam int beat_idx_width = $clog2(beats_per_word);

  // ********************
  // Beat sequencer states
  // ********************

  localparam int seq_state_width = 2;

  localparam logic [seq_state_width-1:0] seq_idle   = 2'd0;
  localparam logic [seq_state_width-1:0] seq_beat   = 2'd1;
  localparam logic [seq_state_width-1:0] seq_finish = 2'd2;

endpackage

`default_nettype wire

// ==== rtl/wb_request_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_request_capture
  import wb_pkg::*;
(
  input  logic                          wb_clk,
  input  logic                          wb_rst,
  input  logic [wb_addr_width-1:0]      wb_adr_i,
  input  logic [wb_data_width-1:0]      wb_dat_i,
  input  logic                          wb_we_i,
  input  logic [wb_sel_width-1:0]       wb_sel_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_ack_i,
  output logic                          cap_valid_o,
  output logic                          cap_we_o,
  output logic [wb_word_adr_width-1:0]  cap_adr_o,
  output logic [wb_data_width-1:0]      cap_dat_o,
  output logic [wb_sel_width-1:0]       cap_sel_o
);

  logic busy;
  logic take;

  // A cycle is taken only while no word is in flight
  assign take = wb_cyc_i && wb_stb_i && !busy;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      busy        <= 1'b0;
      cap_valid_o <= 1'b0;
    end else begin
      cap_valid_o <= 1'b0;
      // Busy still covers the acknowledge cycle, so a strobe left high
      // there is not seen as a new request
      if (wb_ack_i) begin
        busy <= 1'b0;
      end else if (take) begin
        busy        <= 1'b1;
        cap_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk) begin
    if (take) begin
      cap_we_o  <= wb_we_i;
      cap_adr_o <= wb_adr_i[wb_addr_width-1:wb_addr_width-wb_word_adr_width];
      cap_dat_o <= wb_dat_i;
      cap_sel_o <= wb_sel_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hbus_beat_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module hbus_beat_sequencer
  import wb_pkg::*;
  import hbus_pkg::*;
(
  input  logic                          wb_clk,
  input  logic                          wb_rst,
  input  logic                          cap_valid_i,
  input  logic                          cap_we_i,
  input  logic [wb_word_adr_width-1:0]  cap_adr_i,
  input  logic [wb_data_width-1:0]      cap_dat_i,
  input  logic [wb_sel_width-1:0]       cap_sel_i,
  input  logic [hbus_data_width-1:0]    hbus_dat_i,
  input  logic                          hbus_ready_i,
  input  logic                          hbus_valid_i,
  output logic [hbus_addr_width-1:0]    hbus_adr_o,
  output logic [hbus_data_width-1:0]    hbus_dat_o,
  output logic [hbus_mask_width-1:0]    hbus_mask_o,
  output logic                          hbus_rrq_o,
  output logic                          hbus_wrq_o,
  output logic                          beat_done_o,
  output logic [hbus_data_width-1:0]    beat_dat_o,
  output logic [beat_idx_width-1:0]     beat_idx_o,
  output logic                          word_done_o
);

  localparam logic [beat_idx_width-1:0] first_beat = '0;
  localparam logic [beat_idx_width-1:0] last_beat  = beat_idx_width'(beats_per_word - 1);

  logic [seq_state_width-1:0]    state_q;
  logic [beat_idx_width-1:0]     beat_q;
  logic                          we_q;
  logic [wb_word_adr_width-1:0]  adr_q;
  wb_word_u                      dat_q;
  logic [wb_sel_width-1:0]       sel_q;
  logic                          beat_end;
  logic                          last_needed;

  // True when at least one byte lane of the given beat is selected
  function automatic logic lane_active(input logic [wb_sel_width-1:0] sel,
                                       input logic [beat_idx_width-1:0] idx);
    return |sel[idx*hbus_mask_width +: hbus_mask_width];
  endfunction

  // ********************
  // Beat outputs
  // ********************

  assign hbus_adr_o  = hbus_addr_width'({adr_q, beat_q});
  assign hbus_dat_o  = dat_q.half[beat_q];
  assign hbus_mask_o = ~sel_q[beat_q*hbus_mask_width +: hbus_mask_width];
  assign word_done_o = (state_q == seq_finish);

  // The running beat ends on a sampled ready (write) or valid (read)
  assign beat_end = (hbus_wrq_o && hbus_ready_i) || (hbus_rrq_o && hbus_valid_i);

  // Word is finished after this beat if no later beat carries a byte
  assign last_needed = (beat_q == last_beat) ||
                       (we_q && !lane_active(sel_q, beat_q + 1'b1));

  // ********************
  // Beat walk FSM
  // ********************

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state_q     <= seq_idle;
      beat_q      <= first_beat;
      hbus_rrq_o  <= 1'b0;
      hbus_wrq_o  <= 1'b0;
      beat_done_o <= 1'b0;
    end else begin
      beat_done_o <= 1'b0;
      case (state_q)
        seq_idle: begin
          if (cap_valid_i) begin
            if (!cap_we_i) begin
              // Reads always fetch both halves
              hbus_rrq_o <= 1'b1;
              beat_q     <= first_beat;
              state_q    <= seq_beat;
            end else if (lane_active(cap_sel_i, first_beat)) begin
              hbus_wrq_o <= 1'b1;
              beat_q     <= first_beat;
              state_q    <= seq_beat;
            end else if (lane_active(cap_sel_i, last_beat)) begin
              hbus_wrq_o <= 1'b1;
              beat_q     <= last_beat;
              state_q    <= seq_beat;
            end else begin
              // Nothing selected, so the word is done with no bus traffic
              state_q <= seq_finish;
            end
          end
        end

        seq_beat: begin
          if (beat_end) begin
            beat_done_o <= hbus_rrq_o;
            if (last_needed) begin
              hbus_rrq_o <= 1'b0;
              hbus_wrq_o <= 1'b0;
              state_q    <= seq_finish;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end

        seq_finish: begin
          state_q <= seq_idle;
        end

        default: begin
          state_q <= seq_idle;
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk) begin
    if (cap_valid_i) begin
      we_q  <= cap_we_i;
      adr_q <= cap_adr_i;
      dat_q <= cap_dat_i;
      sel_q <= cap_sel_i;
    end
  end

  // Read data goes on to the response stage with the beat it belongs to
  always_ff @(posedge wb_clk) begin
    if (hbus_rrq_o && hbus_valid_i) begin
      beat_dat_o <= hbus_dat_i;
      beat_idx_o <= beat_q;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wb_response_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_response_stage
  import wb_pkg::*;
  import hbus_pkg::*;
(
  input  logic                        wb_clk,
  input  logic                        wb_rst,
  input  logic                        beat_done_i,
  input  logic [hbus_data_width-1:0]  beat_dat_i,
  input  logic [beat_idx_width-1:0]   beat_idx_i,
  input  logic                        word_done_i,
  output logic [wb_data_width-1:0]    wb_dat_o,
  output logic                        wb_ack_o
);

  wb_word_u asm_q;
  wb_word_u asm_next;

  // The last read beat may arrive together with word_done,
  // so the outgoing word is taken from the merged value
  always_comb begin
    asm_next = asm_q;
    if (beat_done_i) begin
      asm_next.half[beat_idx_i] = beat_dat_i;
    end
  end

  always_ff @(posedge wb_clk) begin
    asm_q <= asm_next;
    if (word_done_i) begin
      wb_dat_o <= asm_next;
    end
  end

  // ********************
  // Acknowledge
  // ********************

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= word_done_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hbus_wishbone_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module hbus_wishbone_bridge
  import wb_pkg::*;
  import hbus_pkg::*;
(
  input  logic                        wb_clk,
  input  logic                        wb_rst,
  input  logic [wb_addr_width-1:0]    wb_adr_i,
  input  logic [wb_data_width-1:0]    wb_dat_i,
  input  logic                        wb_we_i,
  input  logic [wb_sel_width-1:0]     wb_sel_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  output logic [wb_data_width-1:0]    wb_dat_o,
  output logic                        wb_ack_o,
  output logic [hbus_addr_width-1:0]  hbus_adr_o,
  input  logic [hbus_data_width-1:0]  hbus_dat_i,
  output logic [hbus_data_width-1:0]  hbus_dat_o,
  output logic [hbus_mask_width-1:0]  hbus_mask_o,
  output logic                        hbus_rrq_o,
  output logic                        hbus_wrq_o,
  input  logic                        hbus_ready_i,
  input  logic                        hbus_valid_i
);

  logic                          cap_valid;
  logic                          cap_we;
  logic [wb_word_adr_width-1:0]  cap_adr;
  logic [wb_data_width-1:0]      cap_dat;
  logic [wb_sel_width-1:0]       cap_sel;

  logic                          beat_done;
  logic [hbus_data_width-1:0]    beat_dat;
  logic [beat_idx_width-1:0]     beat_idx;
  logic                          word_done;

  wb_request_capture u_capture (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_sel_i     (wb_sel_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_i     (wb_ack_o),
    .cap_valid_o  (cap_valid),
    .cap_we_o     (cap_we),
    .cap_adr_o    (cap_adr),
    .cap_dat_o    (cap_dat),
    .cap_sel_o    (cap_sel)
  );

  hbus_beat_sequencer u_sequencer (
    .wb_clk        (wb_clk),
    .wb_rst        (wb_rst),
    .cap_valid_i   (cap_valid),
    .cap_we_i      (cap_we),
    .cap_adr_i     (cap_adr),
    .cap_dat_i     (cap_dat),
    .cap_sel_i     (cap_sel),
    .hbus_dat_i    (hbus_dat_i),
    .hbus_ready_i  (hbus_ready_i),
    .hbus_valid_i  (hbus_valid_i),
    .hbus_adr_o    (hbus_adr_o),
    .hbus_dat_o    (hbus_dat_o),
    .hbus_mask_o   (hbus_mask_o),
    .hbus_rrq_o    (hbus_rrq_o),
    .hbus_wrq_o    (hbus_wrq_o),
    .beat_done_o   (beat_done),
    .beat_dat_o    (beat_dat),
    .beat_idx_o    (beat_idx),
    .word_done_o   (word_done)
  );

  wb_response_stage u_response (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .beat_done_i  (beat_done),
    .beat_dat_i   (beat_dat),
    .beat_idx_i   (beat_idx),
    .word_done_i  (word_done),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o)
  );

endmodule

`default_nettype wire

// ==== testbench/hbus_bridge_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module hbus_bridge_properties
  import hbus_pkg::*;
(
  input logic                        wb_clk,
  input logic                        wb_rst,
  input logic                        wb_ack_i,
  input logic [hbus_addr_width-1:0]  hbus_adr_i,
  input logic [hbus_data_width-1:0]  hbus_dat_i,
  input logic [hbus_mask_width-1:0]  hbus_mask_i,
  input logic                        hbus_rrq_i,
  input logic                        hbus_wrq_i,
  input logic                        hbus_ready_i,
  input logic                        hbus_valid_i
);

  logic waiting;

  // A request is still open when its completing strobe is not seen
  assign waiting = (hbus_wrq_i && !hbus_ready_i) || (hbus_rrq_i && !hbus_valid_i);

  a_one_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
    !(hbus_rrq_i && hbus_wrq_i))
    else $error("read and write request both high");

  a_stable_beat: assert property (@(posedge wb_clk) disable iff (wb_rst)
    waiting |=> ($stable(hbus_adr_i) && $stable(hbus_dat_i) && $stable(hbus_mask_i)))
    else $error("beat changed while its request waited");

  a_ack_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_ack_i |=> !wb_ack_i)
    else $error("acknowledge longer than one cycle");

  a_reset_idle: assert property (@(posedge wb_clk)
    wb_rst |=> (!hbus_rrq_i && !hbus_wrq_i && !wb_ack_i))
    else $error("request active after reset");

endmodule

`default_nettype wire

// ==== testbench/hbus_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module hbus_mem_model
  import hbus_pkg::*;
(
  input  logic                        wb_clk,
  input  logic                        wb_rst,
  input  logic [hbus_addr_width-1:0]  hbus_adr_i,
  input  logic [hbus_data_width-1:0]  hbus_dat_i,
  input  logic [hbus_mask_width-1:0]  hbus_mask_i,
  input  logic                        hbus_rrq_i,
  input  logic                        hbus_wrq_i,
  output logic [hbus_data_width-1:0]  hbus_dat_o,
  output logic                        hbus_ready_o,
  output logic                        hbus_valid_o
);

  logic [hbus_data_width-1:0] mem [0:31];
  logic [15:0]                lfsr_q;
  logic [1:0]                 wait_q;
  logic [4:0]                 idx;

  // Initial contents depend on every address bit of the window
  function automatic logic [15:0] fill_value(input logic [4:0] a);
    return {a, 3'b101, a, 3'b010} ^ 16'h3c96;
  endfunction

  assign idx = hbus_adr_i[4:0];

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      hbus_dat_o   <= '0;
      wait_q       <= 2'd0;
      lfsr_q       <= 16'hace1;
      for (int a = 0; a < 32; a++) begin
        mem[a] <= fill_value(5'(a));
      end
    end else begin
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      // A pulse is consumed on the edge after it rises, then a new latency starts
      if ((hbus_rrq_i || hbus_wrq_i) && !(hbus_ready_o || hbus_valid_o)) begin
        if (wait_q == 2'd0) begin
          if (hbus_wrq_i) begin
            hbus_ready_o <= 1'b1;
            if (!hbus_mask_i[0]) mem[idx][7:0] <= hbus_dat_i[7:0];
            if (!hbus_mask_i[1]) mem[idx][15:8] <= hbus_dat_i[15:8];
          end else begin
            hbus_valid_o <= 1'b1;
            hbus_dat_o   <= mem[idx];
          end
          wait_q <= lfsr_q[1:0];
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top
  import wb_pkg::*;
  import hbus_pkg::*;
();

  localparam int ack_timeout = 200;

  logic                        wb_clk;
  logic                        wb_rst;
  logic [wb_addr_width-1:0]    wb_adr_i;
  logic [wb_data_width-1:0]    wb_dat_i;
  logic                        wb_we_i;
  logic [wb_sel_width-1:0]     wb_sel_i;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic [wb_data_width-1:0]    wb_dat_o;
  logic                        wb_ack_o;
  logic [hbus_addr_width-1:0]  hbus_adr_o;
  logic [hbus_data_width-1:0]  hbus_dat_i;
  logic [hbus_data_width-1:0]  hbus_dat_o;
  logic [hbus_mask_width-1:0]  hbus_mask_o;
  logic                        hbus_rrq_o;
  logic                        hbus_wrq_o;
  logic                        hbus_ready_i;
  logic                        hbus_valid_i;

  wb_word_u    shadow [0:15];
  wb_word_u    exp_word;
  logic        pending_read;
  logic [31:0] lfsr;
  int          value_errors;
  int          timeout_errors;
  int          ack_count;
  int          cycles_presented;
  int          wr_beats;

  hbus_wishbone_bridge dut (.*);

  hbus_mem_model u_mem (
    .wb_clk(wb_clk), .wb_rst(wb_rst), .hbus_adr_i(hbus_adr_o), .hbus_dat_i(hbus_dat_o),
    .hbus_mask_i(hbus_mask_o), .hbus_rrq_i(hbus_rrq_o), .hbus_wrq_i(hbus_wrq_o),
    .hbus_dat_o(hbus_dat_i), .hbus_ready_o(hbus_ready_i), .hbus_valid_o(hbus_valid_i)
  );

  bind hbus_wishbone_bridge hbus_bridge_properties u_props (
    .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_ack_i(wb_ack_o), .hbus_adr_i(hbus_adr_o),
    .hbus_dat_i(hbus_dat_o), .hbus_mask_i(hbus_mask_o), .hbus_rrq_i(hbus_rrq_o),
    .hbus_wrq_i(hbus_wrq_o), .hbus_ready_i(hbus_ready_i), .hbus_valid_i(hbus_valid_i)
  );

  always #50 wb_clk = ~wb_clk;

  // ********************
  // Stimulus helpers
  // ********************

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [15:0] fill_value(input logic [4:0] a);
    return {a, 3'b101, a, 3'b010} ^ 16'h3c96;
  endfunction

  function automatic wb_word_u merge_bytes(input wb_word_u old, input wb_word_u d,
                                           input logic [wb_sel_width-1:0] sel);
    wb_word_u r;
    r = old;
    for (int i = 0; i < wb_sel_width; i++) begin
      if (sel[i]) r.bytes[i] = d.bytes[i];
    end
    return r;
  endfunction

  function automatic wb_word_u ref_read(input logic [3:0] adr);
    return shadow[adr];
  endfunction

  task automatic check_word(input wb_word_u got, input wb_word_u exp);
    if (got !== exp) begin
      value_errors++;
      $display("Fail at %0t: read word %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_beats(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errors++;
      $display("Fail at %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Compare process for acknowledged reads
  always @(posedge wb_clk) begin
    if (wb_ack_o) begin
      ack_count++;
      if (pending_read) check_word(wb_dat_o, exp_word);
    end
    if (hbus_wrq_o && hbus_ready_i) wr_beats++;
  end

  task automatic do_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input logic hold);
    int  wait_cnt;
    int  beats_before;
    int  exp_beats;
    logic got_ack;
    @(negedge wb_clk);
    beats_before = wr_beats;
    exp_beats = int'(|sel[1:0]) + int'(|sel[3:2]);
    exp_word = ref_read(adr);
    pending_read = !we;
    wb_adr_i = {26'd0, adr, 2'b00};
    wb_dat_i = dat;
    wb_we_i = we;
    wb_sel_i = we ? sel : 4'hf;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    cycles_presented++;
    got_ack = 1'b0;
    for (wait_cnt = 0; wait_cnt < ack_timeout && !got_ack; wait_cnt++) begin
      @(negedge wb_clk);
      got_ack = wb_ack_o;
    end
    if (!got_ack) begin
      timeout_errors++;
      $display("Timeout at %0t: no acknowledge for the cycle at word %0d", $time, adr);
    end
    // Keep the strobe up across the edge that ends the acknowledge cycle
    if (hold) @(negedge wb_clk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    if (we && got_ack) begin
      shadow[adr] = merge_bytes(shadow[adr], dat, sel);
      check_beats(wr_beats - beats_before, exp_beats, "write beat");
    end
  endtask

  // ********************
  // Test sequence
  // ********************

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] w;
    wb_clk = 1'b0;
    wb_rst = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_we_i = 1'b0;
    wb_sel_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    lfsr = 32'h164e;
    pending_read = 1'b0;
    exp_word = '0;
    value_errors = 0;
    timeout_errors = 0;
    ack_count = 0;
    cycles_presented = 0;
    wr_beats = 0;
    for (int i = 0; i < 16; i++) begin
      shadow[i].half[0] = fill_value({4'(i), 1'b0});
      shadow[i].half[1] = fill_value({4'(i), 1'b1});
    end
    repeat (10) @(posedge wb_clk);
    @(negedge wb_clk);
    wb_rst = 1'b0;

    take_bits(32, d);
    do_cycle(1'b1, 4'd3, d, 4'hf, 1'b0);
    do_cycle(1'b0, 4'd3, '0, 4'hf, 1'b0);

    for (int i = 0; i < 8; i++) begin
      take_bits(4, a);
      take_bits(32, d);
      take_bits(4, s);
      do_cycle(1'b1, a[3:0], d, s[3:0], 1'b0);
      do_cycle(1'b0, a[3:0], '0, 4'hf, 1'b0);
    end

    take_bits(32, d);
    do_cycle(1'b1, 4'd5, d, 4'b1100, 1'b0);
    do_cycle(1'b1, 4'd6, d, 4'b0011, 1'b0);
    do_cycle(1'b1, 4'd7, d, 4'b0000, 1'b0);
    do_cycle(1'b0, 4'd5, '0, 4'hf, 1'b0);
    do_cycle(1'b0, 4'd7, '0, 4'hf, 1'b0);

    for (int i = 0; i < 40; i++) begin
      take_bits(1, w);
      take_bits(4, a);
      take_bits(32, d);
      take_bits(4, s);
      do_cycle(w[0], a[3:0], d, s[3:0], 1'b0);
    end

    do_cycle(1'b1, 4'd9, 32'h1234_5678, 4'hf, 1'b1);
    do_cycle(1'b0, 4'd9, '0, 4'hf, 1'b1);
    repeat (8) @(negedge wb_clk);
    check_beats(ack_count, cycles_presented, "acknowledge");

    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/wb_pkg.sv
rtl/hbus_pkg.sv
rtl/wb_request_capture.sv
rtl/hbus_beat_sequencer.sv
rtl/wb_response_stage.sv
rtl/hbus_wishbone_bridge.sv
testbench/hbus_bridge_properties.sv
testbench/hbus_mem_model.sv
testbench/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = list.f
PASS_MSG = All tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
